/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module rv_core_tb

sim:
	verilator --binary --timing -f src.f --top-module rv_core_tb
	./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir

/* dv/rv_core_chk.sv */
`default_nettype none

module rv_core_chk (
    input logic              clk,
    input logic              reset,
    input logic              tohost_valid,
    input rv_pkg::word_t     pc,
    input rv_pkg::rf_write_t rf_write
);
    import rv_pkg::*;

    // no report straight out of reset
    tohost_quiet_after_reset: assert property (@(posedge clk) reset |=> !tohost_valid)
        else $error("tohost_valid high in the cycle after reset");

    // fetch address always on a word boundary
    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    // x0 never takes a nonzero value
    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        (rf_write.we && rf_write.addr == '0) |-> rf_write.data == '0)
        else $error("register write to x0 with nonzero data");

endmodule

bind rv_core_top rv_core_chk rv_core_chk_i (
    .clk          (clk),
    .reset        (reset),
    .tohost_valid (tohost_valid),
    .pc           (fetch_decode_i.pc),
    .rf_write     (rf_write)
);

`default_nettype wire

/* dv/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam int NTESTS = 8;
    localparam int MAX_PROG = 16;
    localparam int MAX_EXP = 8;
    localparam int RESET_CYCLES = 5;
    // issue to stage 3 distance, instructions issued meanwhile get cleared
    localparam int CLEAR_LAG = 2;
    localparam int N_STRAIGHT = 5;
    // operand values used by the alu tests
    localparam word_t A_VAL = 32'hFFFF_FFF9;
    localparam word_t B_VAL = 32'h0000_0003;

    logic                      clk;
    logic                      reset;
    logic                      prog_we;
    logic [IMEM_ADDR_BITS-1:0] prog_addr;
    word_t                     prog_data;
    word_t                     tohost;
    logic                      tohost_valid;

    // test table
    string test_name [NTESTS];
    word_t prog [NTESTS][MAX_PROG];
    int    prog_len [NTESTS];
    word_t exp_val [NTESTS][MAX_EXP];
    int    exp_len [NTESTS];
    bit    is_ctr [NTESTS];

    int cur = -1;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 0;

    rv_core_top rv_core_top_i (
        .clk          (clk),
        .reset        (reset),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .tohost       (tohost),
        .tohost_valid (tohost_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, expected tohost reports never arrived", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // instruction formats
    function automatic word_t r_instr(int f7, int rs2, int rs1, int f3, int rd, opcode_t opc);
        r_instr = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic word_t i_instr(int imm, int rs1, int f3, int rd, opcode_t opc);
        i_instr = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic word_t s_instr(int imm, int rs2, int rs1);
        s_instr = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_instr(int imm, int rs2, int rs1, int f3);
        b_instr = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                   7'b1100011};
    endfunction

    function automatic word_t j_instr(int imm, int rd);
        j_instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t addi(int rd, int rs1, int imm);
        addi = i_instr(imm, rs1, 0, rd, OPC_OP_IMM);
    endfunction

    // csrrw x0, tohost, rs1
    function automatic word_t report(int rs1);
        report = i_instr(int'(CSR_TOHOST), rs1, 1, 0, OPC_SYSTEM);
    endfunction

    // jump to self, parks the core
    function automatic word_t halt();
        halt = j_instr(0, 0);
    endfunction

    // branch semantics by funct3
    function automatic bit taken(int f3, word_t a, word_t b);
        case (f3)
            0:       taken = (a == b);
            1:       taken = (a != b);
            4:       taken = ($signed(a) < $signed(b));
            5:       taken = ($signed(a) >= $signed(b));
            6:       taken = (a < b);
            default: taken = (a >= b);
        endcase
    endfunction

    // x1 = -1, x2 = 1 in the branch tests
    function automatic word_t val_of(int r);
        val_of = (r == 1) ? 32'hFFFF_FFFF : (r == 2) ? 32'd1 : 32'd0;
    endfunction

    task automatic start_test(string name, bit ctr);
        cur = cur + 1;
        test_name[cur] = name;
        prog_len[cur] = 0;
        exp_len[cur] = 0;
        is_ctr[cur] = ctr;
    endtask

    task automatic emit(word_t w);
        prog[cur][prog_len[cur]] = w;
        prog_len[cur] = prog_len[cur] + 1;
    endtask

    task automatic want(word_t v);
        exp_val[cur][exp_len[cur]] = v;
        exp_len[cur] = exp_len[cur] + 1;
    endtask

    // x3 = x1 op x2, then report
    task automatic alu_case(int f7, int f3, word_t res);
        emit(r_instr(f7, 2, 1, f3, 3, OPC_OP));
        emit(report(3));
        want(res);
    endtask

    // slot after the branch reports only on fall-through
    task automatic branch_case(int f3, int ra, int rb, int slot);
        emit(b_instr(8, rb, ra, f3));
        emit(report(slot));
        if (!taken(f3, val_of(ra), val_of(rb))) begin
            want(val_of(slot));
        end
    endtask

    task automatic build_tests();
        start_test("alu_rr", 0);
        emit(addi(1, 0, -7));
        emit(addi(2, 0, 3));
        alu_case(0, 0, A_VAL + B_VAL);
        alu_case(32, 0, A_VAL - B_VAL);
        alu_case(0, 7, A_VAL & B_VAL);
        alu_case(0, 6, A_VAL | B_VAL);
        alu_case(0, 4, A_VAL ^ B_VAL);
        alu_case(0, 2, {31'b0, $signed(A_VAL) < $signed(B_VAL)});
        emit(halt());

        start_test("alu_shift", 0);
        emit(addi(1, 0, -7));
        emit(addi(2, 0, 3));
        alu_case(0, 1, A_VAL << B_VAL[4:0]);
        alu_case(0, 5, A_VAL >> B_VAL[4:0]);
        alu_case(32, 5, word_t'($signed(A_VAL) >>> B_VAL[4:0]));
        emit(i_instr(4, 1, 1, 3, OPC_OP_IMM));
        emit(report(3));
        want(A_VAL << 4);
        emit(i_instr(2, 1, 5, 3, OPC_OP_IMM));
        emit(report(3));
        want(A_VAL >> 2);
        // funct7 0100000 in the immediate selects srai
        emit(i_instr('h402, 1, 5, 3, OPC_OP_IMM));
        emit(report(3));
        want(word_t'($signed(A_VAL) >>> 2));
        emit(halt());

        start_test("alu_misc", 0);
        emit(addi(1, 0, -7));
        emit(addi(2, 0, 3));
        alu_case(0, 3, {31'b0, A_VAL < B_VAL});
        emit({20'h12345, 5'd3, 7'b0110111});
        emit(report(3));
        want(32'h1234_5000);
        // back to back chain on x3
        emit(addi(3, 1, 5));
        emit(addi(3, 3, 5));
        emit(report(3));
        want(A_VAL + 32'd10);
        emit(halt());

        start_test("branch_a", 0);
        emit(addi(1, 0, -1));
        emit(addi(2, 0, 1));
        branch_case(0, 1, 2, 0);
        branch_case(1, 1, 2, 1);
        branch_case(4, 1, 2, 2);
        branch_case(5, 1, 2, 1);
        branch_case(6, 1, 2, 2);
        branch_case(7, 1, 2, 0);
        emit(halt());

        start_test("branch_b", 0);
        emit(addi(1, 0, -1));
        emit(addi(2, 0, 1));
        branch_case(0, 1, 1, 0);
        branch_case(1, 1, 1, 1);
        branch_case(4, 2, 1, 2);
        branch_case(5, 2, 1, 1);
        branch_case(6, 2, 1, 2);
        branch_case(7, 2, 1, 0);
        emit(halt());

        start_test("jal", 0);
        emit(addi(1, 0, 5));
        // link is the jal address plus four
        want(word_t'(4 * prog_len[cur] + 4));
        emit(j_instr(8, 4));
        emit(report(1));
        emit(report(4));
        emit(report(1));
        want(32'd5);
        emit(halt());

        start_test("mem", 0);
        // x1 = cafe1234, x2 = 64
        emit({20'hCAFE1, 5'd1, 7'b0110111});
        emit(addi(1, 1, 'h234));
        emit(addi(2, 0, 64));
        emit(s_instr(8, 1, 2));
        emit(i_instr(8, 2, 2, 3, OPC_LOAD));
        // load result read by the very next instruction
        emit(report(3));
        want(32'hCAFE_1234);
        emit(halt());

        start_test("counters", 1);
        emit({20'h80000, 5'd5, 7'b0110111});
        emit(addi(6, 0, 0));
        emit(s_instr(int'(CTR_CLEAR_ADDR - MMIO_BASE), 0, 5));
        for (int i = 0; i < N_STRAIGHT; i++) begin
            emit(addi(7, 0, i));
        end
        emit(i_instr(int'(INSTRET_ADDR - MMIO_BASE), 5, 2, 8, OPC_LOAD));
        emit(report(8));
        // straight-line run plus the load, minus those issued before the clear landed
        want(word_t'(N_STRAIGHT + 1 - CLEAR_LAG));
        emit(i_instr(int'(CYCLE_ADDR - MMIO_BASE), 5, 2, 9, OPC_LOAD));
        emit(report(9));
        want(word_t'(N_STRAIGHT + 1 - CLEAR_LAG));
        emit(halt());
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(string name, word_t expected, word_t actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("ERR %s instret expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // cycle count can never fall below the retired count
    task automatic check_floor(string name, word_t lower, word_t actual);
        checks = checks + 1;
        if (actual < lower) begin
            errors = errors + 1;
            $display("cycle counter %0d is below the retired count %0d in %s",
                     actual, lower, name);
        end
    endtask

    task automatic run_test(int t);
        int got;
        got = 0;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < prog_len[t]; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= IMEM_ADDR_BITS'(i);
            prog_data <= prog[t][i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        reset <= 1'b0;
        // sample mid cycle, tohost is stable there
        while (got < exp_len[t]) begin
            @(negedge clk);
            if (tohost_valid) begin
                if (is_ctr[t] && got == 0) begin
                    check_count(test_name[t], exp_val[t][got], tohost);
                end else if (is_ctr[t]) begin
                    check_floor(test_name[t], exp_val[t][got], tohost);
                end else begin
                    check_word(test_name[t], exp_val[t][got], tohost);
                end
                got = got + 1;
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_tests();
        // no loops in the programs, so one iteration each
        cycle_limit = 200;
        for (int t = 0; t < NTESTS; t++) begin
            cycle_limit = cycle_limit + 4 * prog_len[t] + prog_len[t] + RESET_CYCLES + 2;
        end
        for (int t = 0; t < NTESTS; t++) begin
            run_test(t);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/execute.sv */
`default_nettype none

module execute (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::ex_req_t ex_req,
    output logic            redirect_taken,
    output rv_pkg::word_t   redirect_target,
    output rv_pkg::wb_req_t wb_req,
    output rv_pkg::word_t   tohost,
    output logic            tohost_valid
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;
    alu_op_t    alu_op;
    logic       use_imm;
    word_t      op_b;
    word_t      alu_result;
    logic       br_eq;
    logic       br_lt;
    logic       br_ltu;
    logic       br_cond;
    logic       writes_rd;
    wb_req_t    wb_next;

    assign opcode = opcode_t'(ex_req.instr[6:0]);
    assign funct3 = ex_req.instr[14:12];
    // funct7 bit 5, sub and sra
    assign alt    = ex_req.instr[30];

    // alu op and b operand
    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = (opcode != OPC_OP);
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  alu_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: alu_op = ALU_PASS_B;
            // load and store addresses
            default: alu_op = ALU_ADD;
        endcase
    end

    assign op_b = use_imm ? ex_req.imm : ex_req.rs2_val;

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = ex_req.rs1_val + op_b;
            ALU_SUB:    alu_result = ex_req.rs1_val - op_b;
            ALU_SLL:    alu_result = ex_req.rs1_val << op_b[4:0];
            ALU_SLT:    alu_result = {31'b0, $signed(ex_req.rs1_val) < $signed(op_b)};
            ALU_SLTU:   alu_result = {31'b0, ex_req.rs1_val < op_b};
            ALU_XOR:    alu_result = ex_req.rs1_val ^ op_b;
            ALU_SRL:    alu_result = ex_req.rs1_val >> op_b[4:0];
            ALU_SRA:    alu_result = word_t'($signed(ex_req.rs1_val) >>> op_b[4:0]);
            ALU_OR:     alu_result = ex_req.rs1_val | op_b;
            ALU_AND:    alu_result = ex_req.rs1_val & op_b;
            default:    alu_result = op_b;
        endcase
    end

    // branch compare, always on rs1 and rs2
    assign br_eq  = ex_req.rs1_val == ex_req.rs2_val;
    assign br_lt  = $signed(ex_req.rs1_val) < $signed(ex_req.rs2_val);
    assign br_ltu = ex_req.rs1_val < ex_req.rs2_val;

    always_comb begin
        case (funct3)
            F3_BEQ:  br_cond = br_eq;
            F3_BNE:  br_cond = !br_eq;
            F3_BLT:  br_cond = br_lt;
            F3_BGE:  br_cond = !br_lt;
            F3_BLTU: br_cond = br_ltu;
            F3_BGEU: br_cond = !br_ltu;
            default: br_cond = 1'b0;
        endcase
    end

    assign redirect_taken  = ex_req.valid && opcode == OPC_BRANCH && br_cond;
    assign redirect_target = ex_req.pc + ex_req.imm;

    // csrrw to tohost, rs1 goes out in this cycle
    assign tohost_valid = ex_req.valid && opcode == OPC_SYSTEM && funct3 == F3_CSRRW &&
                          ex_req.instr[31:20] == CSR_TOHOST;
    assign tohost       = ex_req.rs1_val;

    assign writes_rd = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_JAL, OPC_LOAD};

    always_comb begin
        wb_next.alu_result = alu_result;
        wb_next.store_data = ex_req.rs2_val;
        wb_next.pc_plus4   = ex_req.pc + 32'd4;
        wb_next.rd         = ex_req.instr[11:7];
        // writes to x0 dropped here already
        wb_next.reg_we     = ex_req.valid && writes_rd && ex_req.instr[11:7] != '0;
        wb_next.mem_re     = ex_req.valid && opcode == OPC_LOAD;
        wb_next.mem_we     = ex_req.valid && opcode == OPC_STORE;
        wb_next.link       = opcode == OPC_JAL;
        wb_next.valid      = ex_req.valid;
    end

    always_ff @(posedge clk) begin
        wb_req <= wb_next;
        if (reset) begin
            wb_req.valid  <= 1'b0;
            wb_req.reg_we <= 1'b0;
            wb_req.mem_re <= 1'b0;
            wb_req.mem_we <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_decode.sv */
`default_nettype none

module fetch_decode (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               prog_we,
    input  logic [rv_pkg::IMEM_ADDR_BITS-1:0]  prog_addr,
    input  rv_pkg::word_t                      prog_data,
    input  logic                               redirect_taken,
    input  rv_pkg::word_t                      redirect_target,
    input  rv_pkg::rf_write_t                  rf_write,
    output rv_pkg::ex_req_t                    ex_req,
    output logic                               retire
);
    import rv_pkg::*;

    word_t     imem [2**IMEM_ADDR_BITS];
    word_t     pc;
    word_t     pc_next;
    word_t     imem_q;
    word_t     instr;
    word_t     imm;
    word_t     rs1_rf;
    word_t     rs2_rf;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    opcode_t   opcode;
    logic      bubble;
    ex_req_t   ex_next;

    hazard_unit hazard_unit_i (
        .fetched_instr (imem_q),
        .stage2_req    (ex_req),
        .bubble        (bubble)
    );

    // next pc: reset, branch, hold, jal, then sequential
    always_comb begin
        if (reset) begin
            pc_next = RESET_PC;
        end else if (redirect_taken) begin
            pc_next = redirect_target;
        end else if (bubble) begin
            pc_next = pc;
        end else if (opcode == OPC_JAL) begin
            pc_next = pc + imm;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    // program port writes only while the core sits in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
        imem_q <= imem[pc_next[IMEM_ADDR_BITS+1:2]];
        pc     <= pc_next;
    end

    // blocked instruction becomes a nop, refetched next cycle
    assign instr  = bubble ? NOP_INSTR : imem_q;
    assign opcode = opcode_t'(instr[6:0]);
    assign retire = !bubble;

    // immediate by format
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_SYSTEM:
                imm = {{20{instr[31]}}, instr[31:20]};
            OPC_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            OPC_LUI:
                imm = {instr[31:12], 12'b0};
            OPC_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    reg_file reg_file_i (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_rf),
        .rs2_data (rs2_rf),
        .rf_write (rf_write)
    );

    // stage 3 write bypassed into the read
    always_comb begin
        ex_next.instr   = instr;
        ex_next.pc      = pc;
        ex_next.imm     = imm;
        ex_next.valid   = !bubble;
        ex_next.rs1_val = rs1_rf;
        ex_next.rs2_val = rs2_rf;
        if (rf_write.we && rf_write.addr != '0 && rf_write.addr == rs1_addr) begin
            ex_next.rs1_val = rf_write.data;
        end
        if (rf_write.we && rf_write.addr != '0 && rf_write.addr == rs2_addr) begin
            ex_next.rs2_val = rf_write.data;
        end
    end

    always_ff @(posedge clk) begin
        ex_req <= ex_next;
        if (reset) begin
            ex_req.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`default_nettype none

module hazard_unit (
    input  rv_pkg::word_t   fetched_instr,
    input  rv_pkg::ex_req_t stage2_req,
    output logic            bubble
);
    import rv_pkg::*;

    opcode_t   f_opcode;
    opcode_t   s2_opcode;
    reg_addr_t f_rs1;
    reg_addr_t f_rs2;
    reg_addr_t s2_rd;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      s2_writes;
    logic      raw_hit;

    assign f_opcode  = opcode_t'(fetched_instr[6:0]);
    assign f_rs1     = fetched_instr[19:15];
    assign f_rs2     = fetched_instr[24:20];
    assign s2_opcode = opcode_t'(stage2_req.instr[6:0]);
    assign s2_rd     = stage2_req.instr[11:7];

    // source registers by opcode class
    assign uses_rs1 = f_opcode inside {OPC_OP, OPC_OP_IMM, OPC_BRANCH,
                                       OPC_LOAD, OPC_STORE, OPC_SYSTEM};
    assign uses_rs2 = f_opcode inside {OPC_OP, OPC_BRANCH, OPC_STORE};

    // results that only exist after stage 2, jal link included
    assign s2_writes = s2_opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_JAL};

    assign raw_hit = s2_writes && s2_rd != '0 &&
                     ((uses_rs1 && f_rs1 == s2_rd) || (uses_rs2 && f_rs2 == s2_rd));

    // branch resolves in stage 2, load data arrives in stage 3
    assign bubble = stage2_req.valid &&
                    (s2_opcode == OPC_BRANCH || s2_opcode == OPC_LOAD || raw_hit);

endmodule

`default_nettype wire

/* rtl/mem_writeback.sv */
`default_nettype none

module mem_writeback (
    input  logic              clk,
    input  rv_pkg::wb_req_t   wb_req,
    input  rv_pkg::word_t     cycle_count,
    input  rv_pkg::word_t     instret_count,
    output rv_pkg::rf_write_t rf_write,
    output logic              ctr_clear
);
    import rv_pkg::*;

    word_t                     dmem [2**DMEM_ADDR_BITS];
    logic [DMEM_ADDR_BITS-1:0] dmem_idx;
    logic                      is_mmio;
    word_t                     mmio_data;
    word_t                     load_data;

    // word index, address register is the stage 2 to 3 register
    assign dmem_idx = wb_req.alu_result[DMEM_ADDR_BITS+1:2];
    assign is_mmio  = (wb_req.alu_result & MMIO_BASE) != '0;

    always_ff @(posedge clk) begin
        if (wb_req.valid && wb_req.mem_we && !is_mmio) begin
            dmem[dmem_idx] <= wb_req.store_data;
        end
    end

    // counter reads
    always_comb begin
        case (wb_req.alu_result)
            CYCLE_ADDR:   mmio_data = cycle_count;
            INSTRET_ADDR: mmio_data = instret_count;
            default:      mmio_data = '0;
        endcase
    end

    assign load_data = is_mmio ? mmio_data : dmem[dmem_idx];
    assign ctr_clear = wb_req.valid && wb_req.mem_we && wb_req.alu_result == CTR_CLEAR_ADDR;

    // writeback select
    always_comb begin
        rf_write.we   = wb_req.valid && wb_req.reg_we;
        rf_write.addr = wb_req.rd;
        if (wb_req.mem_re) begin
            rf_write.data = load_data;
        end else if (wb_req.link) begin
            rf_write.data = wb_req.pc_plus4;
        end else begin
            rf_write.data = wb_req.alu_result;
        end
    end

endmodule

`default_nettype wire

/* rtl/perf_counters.sv */
`default_nettype none

module perf_counters (
    input  logic          clk,
    input  logic          reset,
    input  logic          retire,
    input  logic          ctr_clear,
    output rv_pkg::word_t cycle_count,
    output rv_pkg::word_t instret_count
);

    // free running cycles, issued instructions
    always_ff @(posedge clk) begin
        if (reset || ctr_clear) begin
            cycle_count   <= '0;
            instret_count <= '0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
            if (retire) begin
                instret_count <= instret_count + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic              clk,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  rv_pkg::rf_write_t rf_write
);
    import rv_pkg::*;

    word_t regs [32];

    // x0 always reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (rf_write.we && rf_write.addr != '0) begin
            regs[rf_write.addr] <= rf_write.data;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_core_top.sv */
`default_nettype none

module rv_core_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              prog_we,
    input  logic [rv_pkg::IMEM_ADDR_BITS-1:0] prog_addr,
    input  rv_pkg::word_t                     prog_data,
    output rv_pkg::word_t                     tohost,
    output logic                              tohost_valid
);
    import rv_pkg::*;

    ex_req_t   ex_req;
    wb_req_t   wb_req;
    rf_write_t rf_write;
    logic      redirect_taken;
    word_t     redirect_target;
    logic      retire;
    logic      ctr_clear;
    word_t     cycle_count;
    word_t     instret_count;

    // stage 1
    fetch_decode fetch_decode_i (
        .clk             (clk),
        .reset           (reset),
        .prog_we         (prog_we),
        .prog_addr       (prog_addr),
        .prog_data       (prog_data),
        .redirect_taken  (redirect_taken),
        .redirect_target (redirect_target),
        .rf_write        (rf_write),
        .ex_req          (ex_req),
        .retire          (retire)
    );

    // stage 2
    execute execute_i (
        .clk             (clk),
        .reset           (reset),
        .ex_req          (ex_req),
        .redirect_taken  (redirect_taken),
        .redirect_target (redirect_target),
        .wb_req          (wb_req),
        .tohost          (tohost),
        .tohost_valid    (tohost_valid)
    );

    // stage 3
    mem_writeback mem_writeback_i (
        .clk           (clk),
        .wb_req        (wb_req),
        .cycle_count   (cycle_count),
        .instret_count (instret_count),
        .rf_write      (rf_write),
        .ctr_clear     (ctr_clear)
    );

    perf_counters perf_counters_i (
        .clk           (clk),
        .reset         (reset),
        .retire        (retire),
        .ctr_clear     (ctr_clear),
        .cycle_count   (cycle_count),
        .instret_count (instret_count)
    );

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes decoded by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    // branch conditions by funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_CSRRW = 3'b001;

    // stage 1 to stage 2
    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t rs1_val;
        word_t rs2_val;
        word_t imm;
        logic  valid;
    } ex_req_t;

    // stage 2 to stage 3
    typedef struct packed {
        word_t     alu_result;
        word_t     store_data;
        word_t     pc_plus4;
        reg_addr_t rd;
        logic      reg_we;
        logic      mem_re;
        logic      mem_we;
        // JAL link, write back pc plus four
        logic      link;
        logic      valid;
    } wb_req_t;

    // writeback port, also feeds the stage 1 bypass
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam int IMEM_ADDR_BITS = 10;
    localparam int DMEM_ADDR_BITS = 10;
    // add x0, x0, x0
    localparam word_t NOP_INSTR = 32'h0000_0033;

    // address map
    localparam word_t MMIO_BASE      = 32'h8000_0000;
    localparam word_t CYCLE_ADDR     = 32'h8000_0010;
    localparam word_t INSTRET_ADDR   = 32'h8000_0014;
    localparam word_t CTR_CLEAR_ADDR = 32'h8000_0018;
    localparam logic [11:0] CSR_TOHOST = 12'h51E;

endpackage

`default_nettype wire

/* src.f */
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/fetch_decode.sv
rtl/execute.sv
rtl/mem_writeback.sv
rtl/perf_counters.sv
rtl/rv_core_top.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv
